/* logic/sdData_config.svh */
`ifndef SD_DATA_CONFIG_SVH
`define SD_DATA_CONFIG_SVH

////////////////////////////////////////
// card bus and FIFO geometry
////////////////////////////////////////

// data lines on the card bus
`define SD_LINES 4

// FIFO word width, both directions
`define WORD_BITS 64

// one nibble per line set per sdClk
`define NIBBLES_PER_WORD 16

// 512 byte block of 8 byte words
`define WORDS_PER_BLOCK 64

////////////////////////////////////////
// per line data CRC
////////////////////////////////////////

`define CRC_BITS 16

// x^16 + x^12 + x^5 + 1, top term implied
`define CRC_POLY 16'h1021

`endif

/* logic/sdDataPkg.sv */
`default_nettype none

`include "sdData_config.svh"

package sdDataPkg;

   typedef logic [`SD_LINES-1:0]                 sdNibble_t;    // one value across the lines
   typedef logic [`WORD_BITS-1:0]                dataWord_t;
   typedef logic [`CRC_BITS-1:0]                 crc16_t;
   typedef logic [`SD_LINES-1:0]                 lineStatus_t;  // crc error flag per line
   typedef logic [$clog2(`WORDS_PER_BLOCK)-1:0]  wordCnt_t;
   typedef logic [$clog2(`NIBBLES_PER_WORD)-1:0] nibbleCnt_t;
   typedef logic [$clog2(`CRC_BITS)-1:0]         crcCnt_t;

   // data bus sequencer
   typedef enum logic [3:0] {
      RESET,
      IDLE,
      WRITE_WAIT,    // first FIFO fetch
      WRITE_WAIT1,
      WRITE_START,   // start nibble
      WRITE,
      WRITE_CRC,
      WRITE_STOP,
      WRITE_TURN,    // bus handed back to the card
      BUSY_CHK,
      NOT_BUSY,
      READ_START,    // wait for card start nibble
      READ,
      READ_CRC,
      CRC_CHK
   } cmdState_t;

   // swap the two nibbles of every byte so that a word shifts out low nibble first
   // in bus order; the swap is its own inverse, so the read side reuses it
   function automatic dataWord_t swapNibbles(input dataWord_t w);
      dataWord_t s;
      int b;
      for (b = 0; b < `WORD_BITS / 8; b++) begin
         s[8*b +: 4]   = w[8*b+4 +: 4];
         s[8*b+4 +: 4] = w[8*b +: 4];
      end
      return s;
   endfunction

endpackage

`default_nettype wire

/* logic/sdCrc16.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sdData_config.svh"

module sdCrc16 (
   input  wire logic                 sdClk,
   input  wire logic                 sysRst,
   input  wire logic                 clear,    // restart for a new block
   input  wire logic                 enable,
   input  wire logic                 bitIn,
   output logic [`CRC_BITS-1:0]      crc
);

   logic feedback;

   assign feedback = bitIn ^ crc[`CRC_BITS-1];

   // serial CRC, one line bit per enabled clock
   always_ff @(posedge sdClk or posedge sysRst) begin
      if (sysRst) begin
         crc <= '0;
      end else if (clear) begin
         crc <= '0;
      end else if (enable) begin
         crc <= {crc[`CRC_BITS-2:0], 1'b0} ^ ({`CRC_BITS{feedback}} & `CRC_POLY);
      end
   end

endmodule

`default_nettype wire

/* logic/sdDataCtrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sdData_config.svh"

module sdDataCtrl (
   input  wire logic                  sdClk,
   input  wire logic                  sysRst,
   input  wire logic                  writeCmd,
   input  wire logic                  readCmd,
   input  wire sdDataPkg::sdNibble_t  sdDataIn,
   output sdDataPkg::cmdState_t       state,
   output sdDataPkg::wordCnt_t        wordCnt,
   output sdDataPkg::nibbleCnt_t      nibbleCnt,
   output sdDataPkg::crcCnt_t         crcCnt,
   output logic                       writeFifoRe,
   output logic                       writeDone
);

   localparam sdDataPkg::nibbleCnt_t lastNibble = sdDataPkg::nibbleCnt_t'(`NIBBLES_PER_WORD - 1);
   localparam sdDataPkg::wordCnt_t   lastWord   = sdDataPkg::wordCnt_t'(`WORDS_PER_BLOCK - 1);

   sdDataPkg::cmdState_t nextState;
   logic                 blockEnd;   // last nibble of the last word
   logic                 dataPhase;

   assign dataPhase = (state == sdDataPkg::WRITE) || (state == sdDataPkg::READ);
   assign blockEnd  = (wordCnt == lastWord) && (nibbleCnt == lastNibble);

   ////////////////////////////////////////
   // sequencer
   ////////////////////////////////////////

   always_comb begin
      nextState = state;
      case (state)
         sdDataPkg::RESET:       nextState = sdDataPkg::IDLE;
         sdDataPkg::IDLE: begin
            if (writeCmd) begin                  // write has priority
               nextState = sdDataPkg::WRITE_WAIT;
            end else if (readCmd) begin
               nextState = sdDataPkg::READ_START;
            end
         end
         sdDataPkg::WRITE_WAIT:  nextState = sdDataPkg::WRITE_WAIT1;
         sdDataPkg::WRITE_WAIT1: nextState = sdDataPkg::WRITE_START;
         sdDataPkg::WRITE_START: nextState = sdDataPkg::WRITE;
         sdDataPkg::WRITE: begin
            if (blockEnd) begin
               nextState = sdDataPkg::WRITE_CRC;
            end
         end
         sdDataPkg::WRITE_CRC: begin
            if (crcCnt == '0) begin
               nextState = sdDataPkg::WRITE_STOP;
            end
         end
         sdDataPkg::WRITE_STOP:  nextState = sdDataPkg::WRITE_TURN;
         sdDataPkg::WRITE_TURN:  nextState = sdDataPkg::BUSY_CHK;
         sdDataPkg::BUSY_CHK: begin
            if (sdDataIn[0]) begin               // card holds D0 low while programming
               nextState = sdDataPkg::NOT_BUSY;
            end
         end
         sdDataPkg::NOT_BUSY:    nextState = sdDataPkg::IDLE;
         sdDataPkg::READ_START: begin
            if (sdDataIn == '0) begin
               nextState = sdDataPkg::READ;
            end
         end
         sdDataPkg::READ: begin
            if (blockEnd) begin
               nextState = sdDataPkg::READ_CRC;
            end
         end
         sdDataPkg::READ_CRC: begin
            if (crcCnt == '0) begin
               nextState = sdDataPkg::CRC_CHK;
            end
         end
         sdDataPkg::CRC_CHK:     nextState = sdDataPkg::IDLE;
         default:                nextState = sdDataPkg::IDLE;
      endcase
   end

   always_ff @(posedge sdClk or posedge sysRst) begin
      if (sysRst) begin
         state <= sdDataPkg::RESET;
      end else begin
         state <= nextState;
      end
   end

   ////////////////////////////////////////
   // block position counters
   ////////////////////////////////////////

   always_ff @(posedge sdClk or posedge sysRst) begin
      if (sysRst) begin
         nibbleCnt <= '0;
         wordCnt   <= '0;
      end else if (state == sdDataPkg::IDLE) begin
         nibbleCnt <= '0;
         wordCnt   <= '0;
      end else if (dataPhase) begin
         nibbleCnt <= nibbleCnt + 1'b1;
         if (nibbleCnt == lastNibble) begin
            wordCnt <= wordCnt + 1'b1;           // wraps to 0 after the block
         end
      end
   end

   // crc bit index, msb first
   always_ff @(posedge sdClk or posedge sysRst) begin
      if (sysRst) begin
         crcCnt <= '1;
      end else if (state == sdDataPkg::IDLE) begin
         crcCnt <= '1;
      end else if (state == sdDataPkg::WRITE_CRC || state == sdDataPkg::READ_CRC) begin
         crcCnt <= crcCnt - 1'b1;
      end
   end

   // one fetch up front, then one per word except after the last
   assign writeFifoRe = (state == sdDataPkg::WRITE_WAIT) ||
                        ((state == sdDataPkg::WRITE) && (nibbleCnt == lastNibble) &&
                         (wordCnt != lastWord));

   always_ff @(posedge sdClk or posedge sysRst) begin
      if (sysRst) begin
         writeDone <= 1'b0;
      end else begin
         writeDone <= (state == sdDataPkg::NOT_BUSY);
      end
   end

   // no fetch may land outside the write frame
   assert property (@(posedge sdClk) disable iff (sysRst)
      writeFifoRe |=> (state == sdDataPkg::WRITE_WAIT1) ||
                      ((state == sdDataPkg::WRITE) && (nibbleCnt == '0)))
      else $error("writeFifoRe data landed outside WRITE_WAIT1/WRITE");

endmodule

`default_nettype wire

/* logic/sdDataTx.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sdData_config.svh"

module sdDataTx (
   input  wire logic                   sdClk,
   input  wire logic                   sysRst,
   input  wire sdDataPkg::cmdState_t   state,
   input  wire sdDataPkg::wordCnt_t    wordCnt,
   input  wire sdDataPkg::nibbleCnt_t  nibbleCnt,
   input  wire sdDataPkg::crcCnt_t     crcCnt,
   input  wire logic                   writeFifoRe,
   input  wire sdDataPkg::dataWord_t   writeData,
   output sdDataPkg::sdNibble_t        sdDataOut,
   output logic                        sdDataEn
);

   logic                  reDly;          // FIFO data valid this cycle
   sdDataPkg::dataWord_t  prefetchWord;
   sdDataPkg::dataWord_t  fetchWord;
   sdDataPkg::dataWord_t  orderedWord;    // nibbles in bus order, low first
   sdDataPkg::dataWord_t  shiftWord;
   sdDataPkg::sdNibble_t  dataNibble;
   sdDataPkg::sdNibble_t  crcNibble;
   sdDataPkg::sdNibble_t  nextNibble;
   logic                  nextEn;
   logic                  crcClear;
   logic                  crcEnable;
   sdDataPkg::crc16_t     txCrc [`SD_LINES];

   ////////////////////////////////////////
   // word fetch and serializer
   ////////////////////////////////////////

   always_ff @(posedge sdClk or posedge sysRst) begin
      if (sysRst) begin
         reDly <= 1'b0;
      end else begin
         reDly <= writeFifoRe;
      end
   end

   always_ff @(posedge sdClk) begin
      if (reDly) begin
         prefetchWord <= writeData;
      end
   end

   // word 0 waits in the prefetch register through WRITE_START,
   // later words arrive from the FIFO right on their first nibble
   assign fetchWord   = (wordCnt == '0) ? prefetchWord : writeData;
   assign orderedWord = sdDataPkg::swapNibbles(fetchWord);
   assign dataNibble  = (nibbleCnt == '0) ? orderedWord[`SD_LINES-1:0]
                                          : shiftWord[`SD_LINES-1:0];

   always_ff @(posedge sdClk) begin
      if (state == sdDataPkg::WRITE) begin
         if (nibbleCnt == '0) begin
            shiftWord <= orderedWord >> `SD_LINES;   // word boundary
         end else begin
            shiftWord <= shiftWord >> `SD_LINES;
         end
      end
   end

   ////////////////////////////////////////
   // line CRCs and pin drivers
   ////////////////////////////////////////

   assign crcClear  = (state == sdDataPkg::IDLE);
   assign crcEnable = (state == sdDataPkg::WRITE);

   for (genvar l = 0; l < `SD_LINES; l++) begin : gTxCrc
      sdCrc16 uTxCrc (
         .sdClk  (sdClk),
         .sysRst (sysRst),
         .clear  (crcClear),
         .enable (crcEnable),
         .bitIn  (dataNibble[l]),
         .crc    (txCrc[l])
      );
   end

   always_comb begin
      for (int l = 0; l < `SD_LINES; l++) begin
         crcNibble[l] = txCrc[l][crcCnt];
      end
      case (state)
         sdDataPkg::WRITE_START: nextNibble = '0;    // start nibble
         sdDataPkg::WRITE:       nextNibble = dataNibble;
         sdDataPkg::WRITE_CRC:   nextNibble = crcNibble;
         default:                nextNibble = '1;    // idle level and stop nibble
      endcase
   end

   assign nextEn = state inside {sdDataPkg::WRITE_START, sdDataPkg::WRITE,
                                 sdDataPkg::WRITE_CRC, sdDataPkg::WRITE_STOP};

   always_ff @(posedge sdClk or posedge sysRst) begin
      if (sysRst) begin
         sdDataOut <= '1;
         sdDataEn  <= 1'b0;
      end else begin
         sdDataOut <= nextNibble;
         sdDataEn  <= nextEn;
      end
   end

   // the card owns the bus for the whole read
   assert property (@(posedge sdClk) disable iff (sysRst)
      $rose(sdDataEn) |-> !(state inside {sdDataPkg::READ_START, sdDataPkg::READ,
                                          sdDataPkg::READ_CRC, sdDataPkg::CRC_CHK}))
      else $error("sdDataEn rose during a read");

endmodule

`default_nettype wire

/* logic/sdDataRx.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sdData_config.svh"

module sdDataRx (
   input  wire logic                   sdClk,
   input  wire logic                   sysRst,
   input  wire sdDataPkg::cmdState_t   state,
   input  wire sdDataPkg::nibbleCnt_t  nibbleCnt,
   input  wire sdDataPkg::crcCnt_t     crcCnt,
   input  wire sdDataPkg::sdNibble_t   sdDataIn,
   output logic                        readFifoWe,
   output sdDataPkg::dataWord_t        readDataOut,
   output logic                        readDone,
   output sdDataPkg::lineStatus_t      dataStatus
);

   localparam sdDataPkg::nibbleCnt_t lastNibble = sdDataPkg::nibbleCnt_t'(`NIBBLES_PER_WORD - 1);

   sdDataPkg::dataWord_t  asmWord;       // received nibbles, first one lowest
   sdDataPkg::dataWord_t  nextAsm;
   logic                  wordEnd;
   logic                  crcClear;
   logic                  crcEnable;
   sdDataPkg::crc16_t     calcCrc [`SD_LINES];
   sdDataPkg::crc16_t     rxCrc   [`SD_LINES];   // as sent by the card

   ////////////////////////////////////////
   // nibble capture
   ////////////////////////////////////////

   assign nextAsm = {sdDataIn, asmWord[`WORD_BITS-1:`SD_LINES]};
   assign wordEnd = (state == sdDataPkg::READ) && (nibbleCnt == lastNibble);

   always_ff @(posedge sdClk) begin
      if (state == sdDataPkg::READ) begin
         asmWord <= nextAsm;
      end
      if (wordEnd) begin
         readDataOut <= sdDataPkg::swapNibbles(nextAsm);   // back to byte order
      end
   end

   always_ff @(posedge sdClk or posedge sysRst) begin
      if (sysRst) begin
         readFifoWe <= 1'b0;
         readDone   <= 1'b0;
      end else begin
         readFifoWe <= wordEnd;
         readDone   <= (state == sdDataPkg::CRC_CHK);
      end
   end

   ////////////////////////////////////////
   // CRC check
   ////////////////////////////////////////

   assign crcClear  = (state == sdDataPkg::IDLE);
   assign crcEnable = (state == sdDataPkg::READ);

   for (genvar l = 0; l < `SD_LINES; l++) begin : gRxCrc
      sdCrc16 uRxCrc (
         .sdClk  (sdClk),
         .sysRst (sysRst),
         .clear  (crcClear),
         .enable (crcEnable),
         .bitIn  (sdDataIn[l]),
         .crc    (calcCrc[l])
      );
   end

   always_ff @(posedge sdClk) begin
      if (state == sdDataPkg::READ_CRC) begin
         for (int l = 0; l < `SD_LINES; l++) begin
            rxCrc[l][crcCnt] <= sdDataIn[l];   // msb arrives first
         end
      end
   end

   // status only moves with readDone
   always_ff @(posedge sdClk or posedge sysRst) begin
      if (sysRst) begin
         dataStatus <= '0;
      end else if (state == sdDataPkg::CRC_CHK) begin
         for (int l = 0; l < `SD_LINES; l++) begin
            dataStatus[l] <= (rxCrc[l] != calcCrc[l]);
         end
      end
   end

   // last word write lands in READ_CRC, well clear of the done pulse
   assert property (@(posedge sdClk) disable iff (sysRst)
      readDone |-> !readFifoWe && !$past(readFifoWe))
      else $error("readFifoWe high with or just before readDone");

endmodule

`default_nettype wire

/* logic/sdDataTop.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sdData_config.svh"

module sdDataTop (
   input  wire logic                   sdClk,
   input  wire logic                   sysRst,
   input  wire logic                   writeCmd,
   input  wire logic                   readCmd,
   input  wire sdDataPkg::dataWord_t   writeData,
   input  wire sdDataPkg::sdNibble_t   sdDataIn,
   output logic                        writeFifoRe,
   output logic                        readFifoWe,
   output sdDataPkg::dataWord_t        readDataOut,
   output logic                        writeDone,
   output logic                        readDone,
   output sdDataPkg::lineStatus_t      dataStatus,
   output sdDataPkg::sdNibble_t        sdDataOut,
   output logic                        sdDataEn
);

   sdDataPkg::cmdState_t   state;
   sdDataPkg::wordCnt_t    wordCnt;
   sdDataPkg::nibbleCnt_t  nibbleCnt;
   sdDataPkg::crcCnt_t     crcCnt;

   // command decode and block timing
   sdDataCtrl u_sdDataCtrl (
      .sdClk       (sdClk),
      .sysRst      (sysRst),
      .writeCmd    (writeCmd),
      .readCmd     (readCmd),
      .sdDataIn    (sdDataIn),
      .state       (state),
      .wordCnt     (wordCnt),
      .nibbleCnt   (nibbleCnt),
      .crcCnt      (crcCnt),
      .writeFifoRe (writeFifoRe),
      .writeDone   (writeDone)
   );

   sdDataTx u_sdDataTx (
      .sdClk       (sdClk),
      .sysRst      (sysRst),
      .state       (state),
      .wordCnt     (wordCnt),
      .nibbleCnt   (nibbleCnt),
      .crcCnt      (crcCnt),
      .writeFifoRe (writeFifoRe),
      .writeData   (writeData),
      .sdDataOut   (sdDataOut),
      .sdDataEn    (sdDataEn)
   );

   sdDataRx u_sdDataRx (
      .sdClk       (sdClk),
      .sysRst      (sysRst),
      .state       (state),
      .nibbleCnt   (nibbleCnt),
      .crcCnt      (crcCnt),
      .sdDataIn    (sdDataIn),
      .readFifoWe  (readFifoWe),
      .readDataOut (readDataOut),
      .readDone    (readDone),
      .dataStatus  (dataStatus)
   );

endmodule

`default_nettype wire

/* dv/sdDataTb.sv */
`timescale 1ns/100ps
`default_nettype none

module sdDataTb;

   localparam int BLOCK_WORDS = 64;
   localparam int WORD_NIBS   = 16;
   localparam int DATA_NIBS   = BLOCK_WORDS * WORD_NIBS;
   localparam int FRAME_LEN   = DATA_NIBS + 18;   // start, data, 16 crc, stop

   logic                    sdClk;
   logic                    sysRst;
   logic                    writeCmd;
   logic                    readCmd;
   sdDataPkg::dataWord_t    writeData;
   sdDataPkg::sdNibble_t    sdDataIn;
   logic                    writeFifoRe;
   logic                    readFifoWe;
   sdDataPkg::dataWord_t    readDataOut;
   logic                    writeDone;
   logic                    readDone;
   sdDataPkg::lineStatus_t  dataStatus;
   sdDataPkg::sdNibble_t    sdDataOut;
   logic                    sdDataEn;

   logic [63:0] txWords[$];     // handed out by the write FIFO model
   logic [63:0] rxWords[$];     // taken in by the read FIFO model
   logic [63:0] cardWords[$];
   logic [63:0] refWords[$];
   logic [3:0]  frame[$];       // enabled write nibbles seen on the pins
   logic [15:0] refCrc [4];
   logic [63:0] fifoWord;
   int          reCount;
   logic        readActive;

   sdDataTop u_sdDataTop (
      .sdClk       (sdClk),
      .sysRst      (sysRst),
      .writeCmd    (writeCmd),
      .readCmd     (readCmd),
      .writeData   (writeData),
      .sdDataIn    (sdDataIn),
      .writeFifoRe (writeFifoRe),
      .readFifoWe  (readFifoWe),
      .readDataOut (readDataOut),
      .writeDone   (writeDone),
      .readDone    (readDone),
      .dataStatus  (dataStatus),
      .sdDataOut   (sdDataOut),
      .sdDataEn    (sdDataEn)
   );

   initial begin
      sdClk = 1'b0;
      forever #2 sdClk = ~sdClk;
   end

   ////////////////////////////////////////
   // failure reporting and helpers
   ////////////////////////////////////////

   task automatic abortRun();
      $display("sim failed");
      $fatal(1, "stopped at the first failure");
   endtask

   task automatic flagValue(input string msg);
      $display("[ERROR] %0t %s", $time, msg);
      abortRun();
   endtask

   task automatic flagTimeout(input string what);
      $display("timeout at %0t: %s", $time, what);
      abortRun();
   endtask

   task automatic nextDriveSlot();
      @(posedge sdClk);
      #1;
   endtask

   // byte idx/2 of the word, high nibble first
   function automatic logic [3:0] busNibble(input logic [63:0] word, input int idx);
      int sh;
      sh = 8 * (idx / 2) + (((idx % 2) == 0) ? 4 : 0);
      return 4'(word >> sh);
   endfunction

   // x^16 + x^12 + x^5 + 1, msb first, zero start
   function automatic logic [15:0] crcNext(input logic [15:0] crc, input logic bitIn);
      logic fb;
      fb = bitIn ^ crc[15];
      return {crc[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
   endfunction

   task automatic computeRefCrcs();
      int w;
      int n;
      int l;
      logic [3:0] nib;
      for (l = 0; l < 4; l++) refCrc[l] = '0;
      for (w = 0; w < BLOCK_WORDS; w++) begin
         for (n = 0; n < WORD_NIBS; n++) begin
            nib = busNibble(refWords[w], n);
            for (l = 0; l < 4; l++) refCrc[l] = crcNext(refCrc[l], nib[l]);
         end
      end
   endtask

   ////////////////////////////////////////
   // FIFO models
   ////////////////////////////////////////

   initial begin
      writeData = '0;
      reCount   = 0;
      forever begin
         @(negedge sdClk);
         if (!sysRst && writeFifoRe) begin
            reCount++;
            fifoWord = {$urandom, $urandom};
            nextDriveSlot();                  // data on the cycle after the strobe
            writeData = fifoWord;
            txWords.push_back(fifoWord);
         end
      end
   end

   initial begin
      forever begin
         @(negedge sdClk);
         if (!sysRst && readFifoWe) rxWords.push_back(readDataOut);
      end
   end

   ////////////////////////////////////////
   // protocol assertions
   ////////////////////////////////////////

   assert property (@(posedge sdClk) disable iff (sysRst) writeDone |=> !writeDone)
      else flagValue("writeDone held for more than one cycle");
   assert property (@(posedge sdClk) disable iff (sysRst) readDone |=> !readDone)
      else flagValue("readDone held for more than one cycle");
   assert property (@(posedge sdClk) disable iff (sysRst)
      (dataStatus != $past(dataStatus)) |-> readDone)
      else flagValue("dataStatus changed without readDone");
   assert property (@(posedge sdClk) disable iff (sysRst) readActive |-> !sdDataEn)
      else flagValue("sdDataEn high while the card owns the bus");

   task automatic checkIdleOutputs();
      assert (!sdDataEn && !writeFifoRe && !readFifoWe && !writeDone && !readDone)
         else flagValue("a strobe or enable is high after reset");
      assert (sdDataOut == 4'hF) else flagValue($sformatf("sdDataOut %h after reset", sdDataOut));
      assert (dataStatus == '0) else flagValue($sformatf("dataStatus %h after reset", dataStatus));
   endtask

   task automatic checkWriteFrame();
      int w;
      int n;
      int l;
      int j;
      int idx;
      logic [3:0] expNib;
      assert (reCount == BLOCK_WORDS)
         else flagValue($sformatf("%0d writeFifoRe pulses, expected 64", reCount));
      assert (frame.size() == FRAME_LEN)
         else flagValue($sformatf("write frame lasted %0d cycles", frame.size()));
      assert (frame[0] == 4'h0) else flagValue($sformatf("start nibble is %h", frame[0]));
      for (w = 0; w < BLOCK_WORDS; w++) begin
         for (n = 0; n < WORD_NIBS; n++) begin
            idx    = 1 + WORD_NIBS * w + n;
            expNib = busNibble(txWords[w], n);
            assert (frame[idx] == expNib)
               else flagValue($sformatf("write nibble %0d is %h, expected %h",
                                        idx - 1, frame[idx], expNib));
         end
      end
      refWords = txWords;
      computeRefCrcs();
      for (j = 0; j < 16; j++) begin
         for (l = 0; l < 4; l++) expNib[l] = 1'(refCrc[l] >> (15 - j));
         idx = 1 + DATA_NIBS + j;
         assert (frame[idx] == expNib)
            else flagValue($sformatf("write crc nibble %0d is %h, expected %h",
                                     j, frame[idx], expNib));
      end
      assert (frame[FRAME_LEN-1] == 4'hF)
         else flagValue($sformatf("stop nibble is %h", frame[FRAME_LEN-1]));
   endtask

   ////////////////////////////////////////
   // block write and read
   ////////////////////////////////////////

   task automatic runWrite();
      int waitCnt;
      int busyCycles;
      nextDriveSlot();
      writeCmd = 1'b1;
      sdDataIn = 4'b1110;                     // card keeps D0 low until programmed
      nextDriveSlot();
      writeCmd = 1'b0;
      waitCnt  = 0;
      @(negedge sdClk);
      while (!sdDataEn) begin
         waitCnt++;
         if (waitCnt > 16) flagTimeout("sdDataEn never rose after the write command");
         @(negedge sdClk);
      end
      while (sdDataEn) begin
         frame.push_back(sdDataOut);
         if (frame.size() > FRAME_LEN + 8) flagTimeout("sdDataEn never fell after the frame");
         @(negedge sdClk);
      end
      busyCycles = 3 + int'($urandom % 30);
      repeat (busyCycles) begin
         assert (!writeDone) else flagValue("writeDone pulsed while the card was busy");
         @(negedge sdClk);
      end
      nextDriveSlot();
      sdDataIn = 4'hF;                        // busy released
      repeat (2) begin
         @(negedge sdClk);
         assert (!writeDone) else flagValue("writeDone came too early after busy release");
      end
      @(negedge sdClk);
      assert (writeDone) else flagValue("writeDone missing after busy release");
      @(negedge sdClk);
      checkWriteFrame();
   endtask

   task automatic runRead(input logic flipCrc, input logic [1:0] badLine);
      int w;
      int n;
      int l;
      int j;
      int waitCnt;
      int rxBase;
      logic [3:0] nib;
      logic [3:0] expStatus;
      cardWords.delete();
      for (w = 0; w < BLOCK_WORDS; w++) cardWords.push_back({$urandom, $urandom});
      refWords = cardWords;
      computeRefCrcs();
      expStatus = '0;
      if (flipCrc) begin
         refCrc[badLine] = refCrc[badLine] ^ (16'h0001 << ($urandom % 16));
         expStatus       = 4'b0001 << badLine;
      end
      rxBase     = rxWords.size();
      readActive = 1'b1;
      nextDriveSlot();
      readCmd = 1'b1;
      nextDriveSlot();
      readCmd = 1'b0;
      repeat (1 + int'($urandom % 4)) nextDriveSlot();   // card access latency
      sdDataIn = 4'h0;                        // start nibble
      for (w = 0; w < BLOCK_WORDS; w++) begin
         for (n = 0; n < WORD_NIBS; n++) begin
            nextDriveSlot();
            sdDataIn = busNibble(cardWords[w], n);
         end
      end
      for (j = 0; j < 16; j++) begin
         for (l = 0; l < 4; l++) nib[l] = 1'(refCrc[l] >> (15 - j));
         nextDriveSlot();
         sdDataIn = nib;
      end
      nextDriveSlot();
      sdDataIn = 4'hF;
      waitCnt  = 0;
      @(negedge sdClk);
      while (!readDone) begin
         waitCnt++;
         if (waitCnt > 8) flagTimeout("readDone never pulsed after the read CRC");
         @(negedge sdClk);
      end
      assert (dataStatus == expStatus)
         else flagValue($sformatf("dataStatus %h, expected %h", dataStatus, expStatus));
      assert (rxWords.size() - rxBase == BLOCK_WORDS)
         else flagValue($sformatf("%0d readFifoWe pulses, expected 64", rxWords.size() - rxBase));
      for (w = 0; w < BLOCK_WORDS; w++) begin
         assert (rxWords[rxBase + w] == cardWords[w])
            else flagValue($sformatf("read word %0d is %h, expected %h",
                                     w, rxWords[rxBase + w], cardWords[w]));
      end
      @(negedge sdClk);
      readActive = 1'b0;
   endtask

   initial begin
      void'($urandom(32'hca8a));
      sysRst     = 1'b1;
      writeCmd   = 1'b0;
      readCmd    = 1'b0;
      sdDataIn   = 4'hF;                      // pulled up lines
      readActive = 1'b0;
      repeat (4) @(posedge sdClk);
      #1 sysRst = 1'b0;
      @(negedge sdClk);
      checkIdleOutputs();
      runWrite();
      runRead(1'b0, 2'd0);
      runRead(1'b1, 2'($urandom % 4));
      repeat (4) @(negedge sdClk);
      $display("sim passed");
      $finish;
   end

endmodule

`default_nettype wire

/* src.f */
+incdir+logic
logic/sdDataPkg.sv
logic/sdCrc16.sv
logic/sdDataCtrl.sv
logic/sdDataTx.sv
logic/sdDataRx.sv
logic/sdDataTop.sv
dv/sdDataTb.sv

/* run.sh */
#!/bin/sh
# build and run the data-bus testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module sdDataTb -Mdir obj_dir -f src.f \
   && ./obj_dir/VsdDataTb > sim.log 2>&1 \
   || echo "build or simulation returned an error"

[ -f sim.log ] && cat sim.log
[ -f sim.log ] || { echo "RESULT: FAIL (no log)"; exit 1; }
grep -q "sim failed" sim.log && { echo "RESULT: FAIL"; exit 1; }
grep -q "sim passed" sim.log || { echo "RESULT: FAIL (run did not finish)"; exit 1; }
echo "RESULT: PASS"
